//--- sources.f
bellek_pkg.sv
bellek_islem_birimi.sv
yukleme_hizalayici.sv
axi_lite_efendi.sv
bellek_birimi_top.sv
tb_axi_bellek.sv
bellek_birimi_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module bellek_birimi_tb \
    -o bellek_sim

./obj_dir/bellek_sim | tee sim.log

grep -q ">>> PASS" sim.log

//--- bellek_birimi_tb.sv
`timescale 1ns/1ps

module bellek_birimi_tb;

    import bellek_pkg::*;

    logic          clk_i;
    logic          reset_i;
    bellek_istek_t istek;
    logic          istek_gecerli;
    logic          istek_hazir;
    bellek_yanit_t yanit;
    logic          yanit_gecerli;
    logic          yanit_hazir;
    axi_efendi_t   axi_m;
    axi_kole_t     axi_s;
    logic [31:0]   shadow [256];
    logic [31:0]   lfsr;
    logic [3:0]    exp_strb;
    logic [31:0]   exp_addr;     // Word address of the pending access
    logic          busless;      // Pending op must not reach the bus
    logic          random_ready;
    logic [4:0]    next_rd;
    logic [31:0]   r;
    logic [31:0]   a;
    logic [31:0]   d;
    int            error_count;
    int            test_count;
    int            test_start_errors;

    bellek_birimi_top dut_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .istek_i         (istek),
        .istek_gecerli_i (istek_gecerli),
        .istek_hazir_o   (istek_hazir),
        .yanit_o         (yanit),
        .yanit_gecerli_o (yanit_gecerli),
        .yanit_hazir_i   (yanit_hazir),
        .axi_o           (axi_m),
        .axi_i           (axi_s)
    );

    tb_axi_bellek bellek_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .axi_i   (axi_m),
        .axi_o   (axi_s)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    held_response: assert property (@(posedge clk_i) disable iff (reset_i)
        yanit_gecerli && !yanit_hazir |=> $stable(yanit))
        else begin
            $display("Response changed while it was still pending");
            error_count++;
        end

    no_accept_while_pending: assert property (@(posedge clk_i) disable iff (reset_i)
        yanit_gecerli |-> !istek_hazir)
        else begin
            $display("istek_hazir_o was high while a response was pending");
            error_count++;
        end

    no_bus_access: assert property (@(posedge clk_i) disable iff (reset_i)
        busless |-> !(axi_m.awvalid || axi_m.wvalid || axi_m.arvalid))
        else begin
            $display("An AXI valid was raised for a NOP or misaligned access");
            error_count++;
        end

    strobe_lanes: assert property (@(posedge clk_i) disable iff (reset_i)
        axi_m.wvalid |-> axi_m.wstrb == exp_strb)
        else begin
            $display("MISMATCH wstrb expected %h got %h", exp_strb, axi_m.wstrb);
            error_count++;
        end

    write_address: assert property (@(posedge clk_i) disable iff (reset_i)
        axi_m.awvalid |-> axi_m.awaddr == exp_addr)
        else begin
            $display("MISMATCH awaddr expected %h got %h", exp_addr, axi_m.awaddr);
            error_count++;
        end

    read_address: assert property (@(posedge clk_i) disable iff (reset_i)
        axi_m.arvalid |-> axi_m.araddr == exp_addr)
        else begin
            $display("MISMATCH araddr expected %h got %h", exp_addr, axi_m.araddr);
            error_count++;
        end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] initial_word(input int i);
        return (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
    endfunction

    function automatic logic is_load(input uop_bel_e u);
        return u inside {UOP_BEL_LW, UOP_BEL_LH, UOP_BEL_LHU, UOP_BEL_LB, UOP_BEL_LBU};
    endfunction

    function automatic logic is_store(input uop_bel_e u);
        return u inside {UOP_BEL_SW, UOP_BEL_SH, UOP_BEL_SB};
    endfunction

    function automatic logic misaligned(input uop_bel_e u, input logic [1:0] off);
        if (u inside {UOP_BEL_LH, UOP_BEL_LHU, UOP_BEL_SH}) return off[0];
        if (u inside {UOP_BEL_LW, UOP_BEL_SW}) return off != 2'd0;
        return 1'b0;
    endfunction

    function automatic logic [3:0] mask_for(input uop_bel_e u, input logic [1:0] off);
        if (misaligned(u, off) || u == UOP_BEL_NOP) return 4'b0000;
        if (u inside {UOP_BEL_LW, UOP_BEL_SW}) return WORD_MASKE;
        if (u inside {UOP_BEL_LH, UOP_BEL_LHU, UOP_BEL_SH})
            return off[1] ? YARIM_MASKE_2 : YARIM_MASKE_0;
        return 4'b0001 << off;
    endfunction

    // Sign or zero extension of the addressed lanes
    function automatic logic [31:0] load_value(input logic [31:0] w, input logic [1:0] off,
                                               input uop_bel_e u);
        logic [31:0] s;
        s = w >> {off, 3'b000};
        case (u)
            UOP_BEL_LW:  return w;
            UOP_BEL_LH:  return {{16{s[15]}}, s[15:0]};
            UOP_BEL_LHU: return {16'h0000, s[15:0]};
            UOP_BEL_LB:  return {{24{s[7]}}, s[7:0]};
            UOP_BEL_LBU: return {24'h000000, s[7:0]};
            default:     return 32'h0000_0000;
        endcase
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    // Runs one request and checks its response, starting on a falling edge
    task automatic run_op(input uop_bel_e uop, input logic [31:0] adres, input logic [31:0] veri);
        logic [1:0]    off;
        logic [7:0]    idx;
        logic          exp_hata;
        logic [31:0]   exp_veri;
        logic [4:0]    exp_rd;
        logic [31:0]   placed;
        logic [31:0]   bit_v;
        bellek_yanit_t got;
        logic          taken;
        int            wait_cnt;
        off      = adres[1:0];
        idx      = adres[9:2];
        exp_rd   = next_rd;
        next_rd  = next_rd + 5'd1;
        exp_hata = misaligned(uop, off) || (adres[12] && uop != UOP_BEL_NOP);
        exp_veri = (is_load(uop) && !exp_hata) ? load_value(shadow[idx], off, uop) : 32'h0;
        wait_cnt = 0;
        while (!istek_hazir) begin
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > 100) stop_on_timeout("istek_hazir_o");
        end
        exp_strb      = mask_for(uop, off);
        exp_addr      = {adres[31:2], 2'b00};
        busless       = misaligned(uop, off) || uop == UOP_BEL_NOP;
        istek.uop     = uop;
        istek.adres   = adres;
        istek.veri    = veri;
        istek.rd      = exp_rd;
        istek_gecerli = 1'b1;
        @(negedge clk_i);
        istek_gecerli = 1'b0;
        taken    = 1'b0;
        wait_cnt = 0;
        while (!taken) begin
            if (random_ready) begin
                draw_bits(1, bit_v);
                yanit_hazir = bit_v[0];
            end else begin
                yanit_hazir = 1'b1;
            end
            if (yanit_gecerli && yanit_hazir) begin
                got   = yanit;   // Taken at the next rising edge
                taken = 1'b1;
            end
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > 200) stop_on_timeout("yanit_gecerli_o");
        end
        busless = 1'b0;
        assert (got.veri == exp_veri) else begin
            $display("MISMATCH yanit_o.veri expected %h got %h", exp_veri, got.veri);
            error_count++;
        end
        assert (got.hata == exp_hata) else begin
            $display("MISMATCH yanit_o.hata expected %h got %h", exp_hata, got.hata);
            error_count++;
        end
        assert (got.rd == exp_rd) else begin
            $display("MISMATCH yanit_o.rd expected %h got %h", exp_rd, got.rd);
            error_count++;
        end
        if (is_store(uop) && !exp_hata) begin
            placed = veri << {off, 3'b000};
            for (int b = 0; b < 4; b++) begin
                if (exp_strb[b]) shadow[idx][8*b +: 8] = placed[8*b +: 8];
            end
        end
    endtask

    initial begin
        reset_i           = 1'b1;
        istek             = '0;
        istek_gecerli     = 1'b0;
        yanit_hazir       = 1'b1;
        busless           = 1'b0;
        random_ready      = 1'b0;
        exp_strb          = 4'b0000;
        exp_addr          = 32'h0000_0000;
        lfsr              = 32'h1748;
        next_rd           = 5'd0;
        error_count       = 0;
        test_count        = 0;
        test_start_errors = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = initial_word(i);
        end
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);

        run_op(UOP_BEL_SW, 32'h0000_0040, 32'hDEAD_BEEF);
        run_op(UOP_BEL_LW, 32'h0000_0040, 32'h0);
        end_test("sw then lw");

        for (int o = 0; o < 4; o++) begin
            run_op(UOP_BEL_SB, 32'h0000_0080 + 32'(o), 32'h0000_00A0 + 32'(o));
            run_op(UOP_BEL_LW, 32'h0000_0080, 32'h0);
        end
        run_op(UOP_BEL_SH, 32'h0000_0084, 32'h0000_1234);
        run_op(UOP_BEL_LW, 32'h0000_0084, 32'h0);
        run_op(UOP_BEL_SH, 32'h0000_0086, 32'h0000_ABCD);
        run_op(UOP_BEL_LW, 32'h0000_0084, 32'h0);
        end_test("byte and halfword lanes");

        run_op(UOP_BEL_SW, 32'h0000_00C0, 32'h80FF_7F01);  // Top bits clear low, set high
        for (int o = 0; o < 4; o++) begin
            run_op(UOP_BEL_LB, 32'h0000_00C0 + 32'(o), 32'h0);
            run_op(UOP_BEL_LBU, 32'h0000_00C0 + 32'(o), 32'h0);
        end
        for (int o = 0; o < 4; o += 2) begin
            run_op(UOP_BEL_LH, 32'h0000_00C0 + 32'(o), 32'h0);
            run_op(UOP_BEL_LHU, 32'h0000_00C0 + 32'(o), 32'h0);
        end
        end_test("load extension");

        run_op(UOP_BEL_LH, 32'h0000_0101, 32'h0);
        run_op(UOP_BEL_SH, 32'h0000_0103, 32'h0000_5555);
        run_op(UOP_BEL_LW, 32'h0000_0102, 32'h0);
        run_op(UOP_BEL_SW, 32'h0000_0101, 32'h1111_2222);
        run_op(UOP_BEL_NOP, 32'h0000_0100, 32'h3333_4444);
        run_op(UOP_BEL_LW, 32'h0000_0100, 32'h0);
        end_test("misaligned and nop");

        run_op(UOP_BEL_SW, 32'h0000_1040, 32'h0BAD_F00D);
        run_op(UOP_BEL_LW, 32'h0000_1040, 32'h0);
        run_op(UOP_BEL_LB, 32'h0000_1041, 32'h0);
        run_op(UOP_BEL_LW, 32'h0000_0040, 32'h0);
        end_test("slverr region");

        random_ready = 1'b1;
        repeat (40) begin
            draw_bits(4, r);
            draw_bits(11, a);
            draw_bits(32, d);
            run_op(uop_bel_e'(r[3:0] % 4'd9), {19'b0, a[10], 2'b00, a[9:0]}, d);
        end
        random_ready = 1'b0;
        yanit_hazir  = 1'b1;
        end_test("random back-pressure");

        $display("tests %0d, errors %0d", test_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb_axi_bellek.sv
`timescale 1ns/1ps

module tb_axi_bellek (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  bellek_pkg::axi_efendi_t axi_i,
    output bellek_pkg::axi_kole_t   axi_o
);

    import bellek_pkg::*;

    logic [31:0] mem [256];
    logic [31:0] lfsr;
    logic [31:0] adim;
    logic [31:0] yeni_kelime;
    logic        aw_bit;
    logic        w_bit;
    logic        ar_bit;
    logic        aw_alindi;
    logic        w_alindi;
    logic [31:0] aw_adres;
    logic [31:0] w_veri;
    logic [3:0]  w_maske;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // Fill pattern depends on every address bit
    function automatic logic [31:0] initial_word(input int i);
        return (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] <= initial_word(i);
        end
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            axi_o     <= '0;
            aw_alindi <= 1'b0;
            w_alindi  <= 1'b0;
            lfsr      <= 32'h1748;
        end else begin
            // One LFSR step per ready decision
            adim   = galois_step(lfsr);
            aw_bit = adim[0];
            adim   = galois_step(adim);
            w_bit  = adim[0];
            adim   = galois_step(adim);
            ar_bit = adim[0];
            lfsr  <= adim;

            axi_o.awready <= axi_i.awvalid && !axi_o.awready && !aw_alindi && aw_bit;
            if (axi_i.awvalid && axi_o.awready) begin
                aw_alindi <= 1'b1;
                aw_adres  <= axi_i.awaddr;
            end
            axi_o.wready <= axi_i.wvalid && !axi_o.wready && !w_alindi && w_bit;
            if (axi_i.wvalid && axi_o.wready) begin
                w_alindi <= 1'b1;
                w_veri   <= axi_i.wdata;
                w_maske  <= axi_i.wstrb;
            end

            if (aw_alindi && w_alindi && !axi_o.bvalid) begin
                if (!aw_adres[12]) begin   // Bit 12 region answers SLVERR
                    yeni_kelime = mem[aw_adres[9:2]];
                    for (int b = 0; b < 4; b++) begin
                        if (w_maske[b]) yeni_kelime[8*b +: 8] = w_veri[8*b +: 8];
                    end
                    mem[aw_adres[9:2]] <= yeni_kelime;
                end
                axi_o.bvalid <= 1'b1;
                axi_o.bresp  <= aw_adres[12] ? 2'b10 : 2'b00;
                aw_alindi    <= 1'b0;
                w_alindi     <= 1'b0;
            end
            if (axi_o.bvalid && axi_i.bready) axi_o.bvalid <= 1'b0;

            axi_o.arready <= axi_i.arvalid && !axi_o.arready && !axi_o.rvalid && ar_bit;
            if (axi_i.arvalid && axi_o.arready) begin
                axi_o.rvalid <= 1'b1;
                axi_o.rdata  <= axi_i.araddr[12] ? 32'h0000_0000 : mem[axi_i.araddr[9:2]];
                axi_o.rresp  <= axi_i.araddr[12] ? 2'b10 : 2'b00;
            end
            if (axi_o.rvalid && axi_i.rready) axi_o.rvalid <= 1'b0;
        end
    end

endmodule

//--- bellek_birimi_top.sv
`timescale 1ns/1ps

module bellek_birimi_top (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  bellek_pkg::bellek_istek_t istek_i,
    input  logic                      istek_gecerli_i,
    output logic                      istek_hazir_o,
    output bellek_pkg::bellek_yanit_t yanit_o,
    output logic                      yanit_gecerli_o,
    input  logic                      yanit_hazir_i,
    output bellek_pkg::axi_efendi_t   axi_o,
    input  bellek_pkg::axi_kole_t     axi_i
);

    import bellek_pkg::*;

    erisim_t erisim; // Çözücüden efendiye

    bellek_islem_birimi islem_birimi_i (
        .istek_i  (istek_i),
        .erisim_o (erisim)
    );

    axi_lite_efendi efendi_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .erisim_i        (erisim),
        .uop_i           (istek_i.uop),
        .rd_i            (istek_i.rd),
        .gecerli_i       (istek_gecerli_i),
        .hazir_o         (istek_hazir_o),
        .axi_o           (axi_o),
        .axi_i           (axi_i),
        .yanit_o         (yanit_o),
        .yanit_gecerli_o (yanit_gecerli_o),
        .yanit_hazir_i   (yanit_hazir_i)
    );

endmodule

//--- axi_lite_efendi.sv
`timescale 1ns/1ps

module axi_lite_efendi (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  bellek_pkg::erisim_t       erisim_i,
    input  bellek_pkg::uop_bel_e      uop_i,
    input  logic [4:0]                rd_i,
    input  logic                      gecerli_i,
    output logic                      hazir_o,
    output bellek_pkg::axi_efendi_t   axi_o,
    input  bellek_pkg::axi_kole_t     axi_i,
    output bellek_pkg::bellek_yanit_t yanit_o,
    output logic                      yanit_gecerli_o,
    input  logic                      yanit_hazir_i
);

    import bellek_pkg::*;

    typedef enum logic [2:0] {
        BOSTA,
        YAZ_ADRES_VERI,
        YAZ_YANIT,
        OKU_ADRES,
        OKU_VERI,
        YANIT
    } durum_e;

    durum_e      durum_q;
    logic        awvalid_q;
    logic        wvalid_q;
    logic        arvalid_q;
    logic [31:0] adres_q;
    logic [31:0] veri_q;
    logic [3:0]  maske_q;
    uop_bel_e    uop_q;
    logic [4:0]  rd_q;
    logic [1:0]  ofset_q;
    logic [31:0] rdata_q;
    logic        hata_q;
    logic [1:0]  ofset_d;
    logic        kabul;
    logic        aw_bitti;
    logic        w_bitti;
    logic [31:0] yukleme_sonuc;

    assign hazir_o = (durum_q == BOSTA);
    assign kabul   = gecerli_i & hazir_o;

    // En düşük etkin şerit bayt ofsetini verir
    always_comb begin
        ofset_d = 2'd3;
        if (erisim_i.maske[2]) ofset_d = 2'd2;
        if (erisim_i.maske[1]) ofset_d = 2'd1;
        if (erisim_i.maske[0]) ofset_d = 2'd0;
    end

    // Bu çevrimde tamamlanan el sıkışmalar dahil
    assign aw_bitti = ~awvalid_q | axi_i.awready;
    assign w_bitti  = ~wvalid_q | axi_i.wready;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            durum_q   <= BOSTA;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            arvalid_q <= 1'b0;
        end else begin
            case (durum_q)
                BOSTA: begin
                    if (kabul) begin
                        if (erisim_i.yaz) begin
                            awvalid_q <= 1'b1; // AW ve W birlikte kalkar
                            wvalid_q  <= 1'b1;
                            durum_q   <= YAZ_ADRES_VERI;
                        end else if (erisim_i.oku) begin
                            arvalid_q <= 1'b1;
                            durum_q   <= OKU_ADRES;
                        end else begin
                            durum_q   <= YANIT; // NOP ya da hizasız
                        end
                    end
                end
                YAZ_ADRES_VERI: begin
                    if (axi_i.awready) awvalid_q <= 1'b0;
                    if (axi_i.wready) wvalid_q <= 1'b0;
                    if (aw_bitti && w_bitti) durum_q <= YAZ_YANIT;
                end
                YAZ_YANIT: begin
                    if (axi_i.bvalid) durum_q <= YANIT;
                end
                OKU_ADRES: begin
                    if (axi_i.arready) begin
                        arvalid_q <= 1'b0;
                        durum_q   <= OKU_VERI;
                    end
                end
                OKU_VERI: begin
                    if (axi_i.rvalid) durum_q <= YANIT;
                end
                YANIT: begin
                    if (yanit_hazir_i) durum_q <= BOSTA; // Geri basınçta bekle
                end
                default: durum_q <= BOSTA;
            endcase
        end
    end

    // İstek ve yanıt yükü
    always_ff @(posedge clk_i) begin
        if (kabul) begin
            adres_q <= erisim_i.adres;
            veri_q  <= erisim_i.veri;
            maske_q <= erisim_i.maske;
            uop_q   <= uop_i;
            rd_q    <= rd_i;
            ofset_q <= ofset_d;
            rdata_q <= 32'h0000_0000;
            hata_q  <= erisim_i.hizasiz;
        end
        if ((durum_q == YAZ_YANIT) && axi_i.bvalid) begin
            hata_q <= (axi_i.bresp != AXI_OKAY);
        end
        if ((durum_q == OKU_VERI) && axi_i.rvalid) begin
            hata_q  <= (axi_i.rresp != AXI_OKAY);
            rdata_q <= (axi_i.rresp == AXI_OKAY) ? axi_i.rdata : 32'h0000_0000;
        end
    end

    yukleme_hizalayici hizalayici_i (
        .kelime_i (rdata_q),
        .ofset_i  (ofset_q),
        .uop_i    (uop_q),
        .sonuc_o  (yukleme_sonuc)
    );

    assign axi_o.awaddr  = adres_q;
    assign axi_o.awvalid = awvalid_q;
    assign axi_o.wdata   = veri_q;
    assign axi_o.wstrb   = maske_q;
    assign axi_o.wvalid  = wvalid_q;
    assign axi_o.bready  = (durum_q == YAZ_YANIT);
    assign axi_o.araddr  = adres_q;
    assign axi_o.arvalid = arvalid_q;
    assign axi_o.rready  = (durum_q == OKU_VERI);

    assign yanit_o.veri    = yukleme_sonuc;
    assign yanit_o.rd      = rd_q;
    assign yanit_o.hata    = hata_q;
    assign yanit_gecerli_o = (durum_q == YANIT);

    aw_tutulur: assert property (@(posedge clk_i) disable iff (reset_i)
        axi_o.awvalid && !axi_i.awready |=> axi_o.awvalid && $stable(axi_o.awaddr));

    w_tutulur: assert property (@(posedge clk_i) disable iff (reset_i)
        axi_o.wvalid && !axi_i.wready |=>
            axi_o.wvalid && $stable(axi_o.wdata) && $stable(axi_o.wstrb));

    ar_tutulur: assert property (@(posedge clk_i) disable iff (reset_i)
        axi_o.arvalid && !axi_i.arready |=> axi_o.arvalid && $stable(axi_o.araddr));

    // Bekleyen yanıt sabit kalır, yeni istek alınmaz
    yanit_tutulur: assert property (@(posedge clk_i) disable iff (reset_i)
        yanit_gecerli_o && !yanit_hazir_i |=>
            yanit_gecerli_o && !hazir_o && $stable(yanit_o));

endmodule

//--- yukleme_hizalayici.sv
`timescale 1ns/1ps

module yukleme_hizalayici (
    input  logic [31:0]          kelime_i,
    input  logic [1:0]           ofset_i,
    input  bellek_pkg::uop_bel_e uop_i,
    output logic [31:0]          sonuc_o
);

    import bellek_pkg::*;

    logic [31:0] kaydirilmis;
    logic [7:0]  bayt;
    logic [15:0] yarim;

    // Adreslenen bayt ya da yarım kelime bit 0'a iner
    assign kaydirilmis = kelime_i >> {ofset_i, 3'b000};
    assign bayt        = kaydirilmis[7:0];
    assign yarim       = kaydirilmis[15:0];

    always_comb begin
        case (uop_i)
            UOP_BEL_LW: begin
                sonuc_o = kelime_i;
            end
            UOP_BEL_LH: begin
                sonuc_o = {{16{yarim[15]}}, yarim};  // İşaretli
            end
            UOP_BEL_LHU: begin
                sonuc_o = {16'h0000, yarim};
            end
            UOP_BEL_LB: begin
                sonuc_o = {{24{bayt[7]}}, bayt};     // İşaretli
            end
            UOP_BEL_LBU: begin
                sonuc_o = {24'h000000, bayt};
            end
            default: begin
                sonuc_o = 32'h0000_0000; // Store ve NOP sıfır döner
            end
        endcase
    end

endmodule

//--- bellek_islem_birimi.sv
`timescale 1ns/1ps

module bellek_islem_birimi (
    input  bellek_pkg::bellek_istek_t istek_i,
    output bellek_pkg::erisim_t       erisim_o
);

    import bellek_pkg::*;

    typedef enum logic [1:0] {
        BOYUT_YOK,
        BOYUT_BYTE,
        BOYUT_YARIM,
        BOYUT_KELIME
    } boyut_e;

    boyut_e     boyut;
    logic [1:0] ofset;
    logic       yukleme;
    logic       saklama;
    logic       hizasiz;

    // Boyut ve adresin alt bitlerinden şerit maskesi
    function automatic logic [3:0] maske_sec(input boyut_e boyut_f, input logic [1:0] ofset_f);
        logic [3:0] m;
        m = 4'b0000;
        case (boyut_f)
            BOYUT_BYTE: begin
                case (ofset_f)
                    2'd0:    m = BYTE_MASKE_0;
                    2'd1:    m = BYTE_MASKE_1;
                    2'd2:    m = BYTE_MASKE_2;
                    default: m = BYTE_MASKE_3;
                endcase
            end
            BOYUT_YARIM:  m = ofset_f[1] ? YARIM_MASKE_2 : YARIM_MASKE_0;
            BOYUT_KELIME: m = WORD_MASKE;
            default:      m = 4'b0000;
        endcase
        return m;
    endfunction

    assign ofset = istek_i.adres[1:0];

    always_comb begin
        boyut   = BOYUT_YOK;
        yukleme = 1'b0;
        saklama = 1'b0;
        case (istek_i.uop)
            UOP_BEL_LW: begin
                boyut   = BOYUT_KELIME;
                yukleme = 1'b1;
            end
            UOP_BEL_LH, UOP_BEL_LHU: begin // İşaret uzatması hizalayıcıda
                boyut   = BOYUT_YARIM;
                yukleme = 1'b1;
            end
            UOP_BEL_LB, UOP_BEL_LBU: begin
                boyut   = BOYUT_BYTE;
                yukleme = 1'b1;
            end
            UOP_BEL_SW: begin
                boyut   = BOYUT_KELIME;
                saklama = 1'b1;
            end
            UOP_BEL_SH: begin
                boyut   = BOYUT_YARIM;
                saklama = 1'b1;
            end
            UOP_BEL_SB: begin
                boyut   = BOYUT_BYTE;
                saklama = 1'b1;
            end
            default: ; // NOP, bus'a dokunmaz
        endcase
    end

    // Tek ofsette yarım kelime, sıfır olmayan ofsette kelime
    assign hizasiz = ((boyut == BOYUT_YARIM) && ofset[0]) ||
                     ((boyut == BOYUT_KELIME) && (ofset != 2'd0));

    always_comb begin
        erisim_o.hizasiz = hizasiz;
        erisim_o.oku     = yukleme & ~hizasiz;
        erisim_o.yaz     = saklama & ~hizasiz;
        erisim_o.maske   = hizasiz ? 4'b0000 : maske_sec(boyut, ofset);
        erisim_o.adres   = {istek_i.adres[31:2], 2'b00};
        erisim_o.veri    = istek_i.veri << {ofset, 3'b000}; // Veriyi adreslenen şeride kaydır
    end

    always_comb begin
        assert (!(erisim_o.oku && erisim_o.yaz))
            else $error("bellek_islem_birimi: oku and yaz both high");
    end

endmodule

//--- bellek_pkg.sv
package bellek_pkg;

    // Bellek mikro-işlem türleri
    typedef enum logic [3:0] {
        UOP_BEL_NOP = 4'd0,
        UOP_BEL_LW  = 4'd1,
        UOP_BEL_LH  = 4'd2,
        UOP_BEL_LHU = 4'd3,
        UOP_BEL_LB  = 4'd4,
        UOP_BEL_LBU = 4'd5,
        UOP_BEL_SW  = 4'd6,
        UOP_BEL_SH  = 4'd7,
        UOP_BEL_SB  = 4'd8
    } uop_bel_e;

    // Bayt şerit maskeleri
    localparam logic [3:0] BYTE_MASKE_0  = 4'b0001;
    localparam logic [3:0] BYTE_MASKE_1  = 4'b0010;
    localparam logic [3:0] BYTE_MASKE_2  = 4'b0100;
    localparam logic [3:0] BYTE_MASKE_3  = 4'b1000;
    localparam logic [3:0] YARIM_MASKE_0 = 4'b0011;
    localparam logic [3:0] YARIM_MASKE_2 = 4'b1100;
    localparam logic [3:0] WORD_MASKE    = 4'b1111;

    localparam logic [1:0] AXI_OKAY = 2'b00;

    typedef struct packed {
        uop_bel_e    uop;
        logic [31:0] adres;
        logic [31:0] veri;   // Saklanacak veri, şeritlenmemiş
        logic [4:0]  rd;
    } bellek_istek_t;

    typedef struct packed {
        logic [31:0] veri;   // Yükleme sonucu
        logic [4:0]  rd;
        logic        hata;
    } bellek_yanit_t;

    // Efendinin sürdüğü AXI4-Lite sinyalleri
    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axi_efendi_t;

    // Kölenin sürdüğü AXI4-Lite sinyalleri
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axi_kole_t;

    typedef struct packed {
        logic [3:0]  maske;
        logic        oku;
        logic        yaz;
        logic        hizasiz;
        logic [31:0] adres;  // Kelimeye hizalı
        logic [31:0] veri;   // Şeritlere yerleşmiş
    } erisim_t;

endpackage
